// File: design/cbus_cfg_pkg.sv
package cbus_cfg_pkg;

  localparam int unsigned CBUS_ADDR_W     = 32;
  localparam int unsigned CBUS_DATA_W     = 32;
  localparam int unsigned CBUS_N_INIT     = 4;  // Core data, instr, DMA, ext slave
  localparam int unsigned CBUS_N_TGT      = 3;  // TCDM, periph, ext master
  localparam int unsigned CBUS_INIT_IDX_W = $clog2(CBUS_N_INIT);

  localparam int unsigned CLUSTER_ID_W = 6;

  localparam logic [CBUS_ADDR_W-1:0] CLUSTER_BASE  = 32'h1000_0000;
  localparam logic [CBUS_ADDR_W-1:0] TCDM_SIZE     = 32'h0002_0000;  // 128 KiB
  localparam logic [CBUS_ADDR_W-1:0] PERIPH_OFFSET = 32'h0020_0000;
  localparam logic [CBUS_ADDR_W-1:0] EXT_OFFSET    = 32'h0040_0000;

  // Each cluster owns one EXT_OFFSET window, so the id starts right above it
  localparam int unsigned CLUSTER_ID_SHIFT = $clog2(EXT_OFFSET);

  // In-cluster offset below the peripheral flag and the gap flag
  localparam int unsigned CBUS_OFFSET_W = $clog2(PERIPH_OFFSET) - 1;

  localparam int unsigned CBUS_PREFIX_W = CBUS_ADDR_W - CLUSTER_ID_SHIFT - CLUSTER_ID_W;

  // Target response timeout
  localparam int unsigned TIMEOUT_CYCLES = 16;
  localparam int unsigned TIMEOUT_CNT_W  = $clog2(TIMEOUT_CYCLES);

endpackage

// File: design/cbus_types_pkg.sv
package cbus_types_pkg;

  // Target port index, also the position in the tgt_* vectors
  typedef enum logic [1:0] {
    TGT_TCDM   = 2'd0,
    TGT_PERIPH = 2'd1,
    TGT_EXT    = 2'd2
  } cbus_tgt_e;

  typedef enum logic [2:0] {
    IDLE,   // Waiting for a request
    ISSUE,  // Transfer on the link, target request raised on a hit
    WAIT,   // Target request held
    RESP,   // Response pulse to the initiator
    ERR     // Error response, miss or timeout
  } cbus_state_e;

  // One address word seen flat or split along the cluster map
  typedef union packed {
    logic [cbus_cfg_pkg::CBUS_ADDR_W-1:0] word;  // Flat compare for the ext area
    struct packed {
      logic [cbus_cfg_pkg::CBUS_PREFIX_W-1:0] prefix;      // Cluster space prefix
      logic [cbus_cfg_pkg::CLUSTER_ID_W-1:0]  cluster_id;
      logic                                   periph;      // Upper 2 MiB of the window
      logic                                   gap;         // Unmapped space above TCDM
      logic [cbus_cfg_pkg::CBUS_OFFSET_W-1:0] offset;
    } cluster;
  } cbus_addr_u;

endpackage

// File: design/cbus_link_if.sv
interface cbus_link_if;
  import cbus_cfg_pkg::*;
  import cbus_types_pkg::*;

  logic                   req;     // Held from grant until response
  logic [CBUS_ADDR_W-1:0] addr;
  logic                   we;
  logic [CBUS_DATA_W-1:0] wdata;
  cbus_tgt_e              tgt_sel;
  logic                   hit;
  logic                   rvalid;  // Single-cycle pulse from the chosen target
  logic [CBUS_DATA_W-1:0] rdata;

  modport mux (
    output req, addr, we, wdata, rvalid, rdata,
    input  tgt_sel
  );

  modport dec (
    input  addr,
    output tgt_sel, hit
  );

  modport fsm (
    input req, hit, rvalid
  );

  // Read-only view of the returned response
  modport resp (
    input rvalid, rdata, tgt_sel
  );

endinterface

// File: design/cbus_arbiter_fsm.sv
module cbus_arbiter_fsm (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic [cbus_cfg_pkg::CBUS_N_INIT-1:0]     init_req_i,
  cbus_link_if.fsm                                 link,
  input  logic                                     timeout_i,
  output logic [cbus_cfg_pkg::CBUS_INIT_IDX_W-1:0] grant_o,
  output logic                                     gnt_valid_o,
  output logic                                     tgt_en_o,
  output logic                                     resp_en_o,
  output logic                                     err_o,
  output logic                                     timer_start_o
);
  import cbus_cfg_pkg::*;
  import cbus_types_pkg::*;

  cbus_state_e                state_q;
  cbus_state_e                state_d;
  logic [CBUS_INIT_IDX_W-1:0] grant_q;  // Also the round-robin pointer
  logic [CBUS_INIT_IDX_W-1:0] pick;
  logic                       found;
  logic                       tgt_ok;

  // Search the requests starting one past the last grant
  always_comb begin
    int unsigned cand;
    pick  = grant_q;
    found = 1'b0;
    for (int unsigned i = 1; i <= CBUS_N_INIT; i++) begin
      cand = (grant_q + i) % CBUS_N_INIT;
      if (!found && init_req_i[cand]) begin
        pick  = CBUS_INIT_IDX_W'(cand);
        found = 1'b1;
      end
    end
  end

  assign tgt_ok = link.req && link.hit;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (found) state_d = ISSUE;
      end
      ISSUE: begin
        if (!tgt_ok) state_d = ERR;  // No target for this address
        else if (link.rvalid) state_d = RESP;
        else state_d = WAIT;
      end
      WAIT: begin
        if (link.rvalid) state_d = RESP;
        else if (timeout_i) state_d = ERR;
      end
      RESP, ERR: state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      grant_q <= CBUS_INIT_IDX_W'(CBUS_N_INIT - 1);  // First search lands on initiator 0
    end else begin
      state_q <= state_d;
      if (gnt_valid_o) grant_q <= pick;
    end
  end

  assign gnt_valid_o   = (state_q == IDLE) && found;
  assign grant_o       = (state_q == IDLE) ? pick : grant_q;
  assign tgt_en_o      = ((state_q == ISSUE) && tgt_ok) || (state_q == WAIT);
  assign timer_start_o = (state_q == ISSUE) && tgt_ok && !link.rvalid;
  assign resp_en_o     = (state_q == RESP) || (state_q == ERR);
  assign err_o         = (state_q == ERR);

  a_resp_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_en_o |=> !resp_en_o);

  // Mux keeps steering the same initiator until its response is out
  a_grant_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_valid_o |=> $stable(grant_o) throughout resp_en_o [->1]);

endmodule

// File: design/cbus_timeout_timer.sv
module cbus_timeout_timer (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic start_i,
  input  logic stop_i,
  output logic expired_o
);
  import cbus_cfg_pkg::*;

  logic [TIMEOUT_CNT_W-1:0] cnt_q;
  logic                     running_q;
  logic                     expired_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q     <= '0;
      running_q <= 1'b0;
      expired_q <= 1'b0;
    end else begin
      expired_q <= 1'b0;
      if (start_i) begin
        cnt_q     <= TIMEOUT_CNT_W'(TIMEOUT_CYCLES - 1);
        running_q <= 1'b1;
      end else if (stop_i) begin
        running_q <= 1'b0;  // Target answered in time
      end else if (running_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == '0) begin
          running_q <= 1'b0;
          expired_q <= 1'b1;
        end
      end
    end
  end

  assign expired_o = expired_q;

  a_no_expiry_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !running_q |=> !expired_o);

endmodule

// File: design/cbus_addr_decoder.sv
module cbus_addr_decoder (
  input  logic [cbus_cfg_pkg::CLUSTER_ID_W-1:0] cluster_id_i,
  cbus_link_if.dec                              link
);
  import cbus_cfg_pkg::*;
  import cbus_types_pkg::*;

  cbus_addr_u             addr_u;
  cbus_addr_u             base_u;
  logic [CBUS_ADDR_W-1:0] ext_start;
  logic                   in_cluster;
  logic                   in_tcdm;
  logic                   in_ext;

  assign addr_u      = link.addr;
  assign base_u.word = CLUSTER_BASE + (CBUS_ADDR_W'(cluster_id_i) << CLUSTER_ID_SHIFT);
  assign ext_start   = base_u.word + EXT_OFFSET;

  // Everything from the end of this cluster window upward goes out
  assign in_ext = (addr_u.word >= ext_start);

  // Same prefix and id as the base
  assign in_cluster = (addr_u.cluster.prefix == base_u.cluster.prefix) &&
                      (addr_u.cluster.cluster_id == base_u.cluster.cluster_id);

  assign in_tcdm = in_cluster && !addr_u.cluster.periph && !addr_u.cluster.gap &&
                   (addr_u.cluster.offset < TCDM_SIZE[CBUS_OFFSET_W-1:0]);

  always_comb begin
    link.tgt_sel = TGT_EXT;
    link.hit     = 1'b0;
    if (in_ext) begin
      link.tgt_sel = TGT_EXT;
      link.hit     = 1'b1;
    end else if (in_cluster && addr_u.cluster.periph) begin
      link.tgt_sel = TGT_PERIPH;
      link.hit     = 1'b1;
    end else if (in_tcdm) begin
      link.tgt_sel = TGT_TCDM;
      link.hit     = 1'b1;
    end
    // Below the base or in the hole past TCDM: miss
  end

endmodule

// File: design/cbus_target_mux.sv
module cbus_target_mux (
  input  logic                                                         clk_i,
  input  logic                                                         rst_n_i,
  input  logic [cbus_cfg_pkg::CBUS_N_INIT-1:0][cbus_cfg_pkg::CBUS_ADDR_W-1:0] init_addr_i,
  input  logic [cbus_cfg_pkg::CBUS_N_INIT-1:0]                         init_we_i,
  input  logic [cbus_cfg_pkg::CBUS_N_INIT-1:0][cbus_cfg_pkg::CBUS_DATA_W-1:0] init_wdata_i,
  output logic [cbus_cfg_pkg::CBUS_N_INIT-1:0]                         init_rvalid_o,
  output logic [cbus_cfg_pkg::CBUS_N_INIT-1:0][cbus_cfg_pkg::CBUS_DATA_W-1:0] init_rdata_o,
  output logic [cbus_cfg_pkg::CBUS_N_INIT-1:0]                         init_err_o,
  input  logic [cbus_cfg_pkg::CBUS_INIT_IDX_W-1:0]                     grant_i,
  input  logic                                                         gnt_valid_i,
  input  logic                                                         tgt_en_i,
  input  logic                                                         resp_en_i,
  input  logic                                                         err_i,
  output logic [cbus_cfg_pkg::CBUS_N_TGT-1:0]                          tgt_req_o,
  output logic [cbus_cfg_pkg::CBUS_N_TGT-1:0][cbus_cfg_pkg::CBUS_ADDR_W-1:0]  tgt_addr_o,
  output logic [cbus_cfg_pkg::CBUS_N_TGT-1:0]                          tgt_we_o,
  output logic [cbus_cfg_pkg::CBUS_N_TGT-1:0][cbus_cfg_pkg::CBUS_DATA_W-1:0]  tgt_wdata_o,
  input  logic [cbus_cfg_pkg::CBUS_N_TGT-1:0]                          tgt_rvalid_i,
  input  logic [cbus_cfg_pkg::CBUS_N_TGT-1:0][cbus_cfg_pkg::CBUS_DATA_W-1:0]  tgt_rdata_i,
  cbus_link_if.mux                                                     link
);
  import cbus_cfg_pkg::*;
  import cbus_types_pkg::*;

  logic [CBUS_DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) link.req <= 1'b0;
    else if (gnt_valid_i) link.req <= 1'b1;
    else if (resp_en_i) link.req <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (gnt_valid_i) begin  // Latch the granted initiator's transfer
      link.addr  <= init_addr_i[grant_i];
      link.we    <= init_we_i[grant_i];
      link.wdata <= init_wdata_i[grant_i];
    end
    if (link.rvalid) rdata_q <= link.rdata;
  end

  assign link.rvalid = tgt_en_i && tgt_rvalid_i[link.tgt_sel];
  assign link.rdata  = tgt_rdata_i[link.tgt_sel];

  always_comb begin
    for (int t = 0; t < CBUS_N_TGT; t++) begin
      tgt_req_o[t]   = tgt_en_i && (link.tgt_sel == cbus_tgt_e'(t));
      tgt_addr_o[t]  = link.addr;
      tgt_we_o[t]    = link.we;
      tgt_wdata_o[t] = link.wdata;
    end
  end

  always_comb begin
    for (int n = 0; n < CBUS_N_INIT; n++) begin
      init_rvalid_o[n] = resp_en_i && (grant_i == CBUS_INIT_IDX_W'(n));
      init_err_o[n]    = resp_en_i && err_i && (grant_i == CBUS_INIT_IDX_W'(n));
      init_rdata_o[n]  = rdata_q;
    end
  end

  a_tgt_req_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(tgt_req_o));

  // A pending target request never moves to another target
  a_tgt_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (tgt_req_o != '0) && !link.rvalid |=> (tgt_req_o == $past(tgt_req_o)) || (tgt_req_o == '0));

endmodule

// File: design/cluster_bus_top.sv
module cluster_bus_top (
  input  logic                                                         clk_i,
  input  logic                                                         rst_n_i,
  input  logic [cbus_cfg_pkg::CLUSTER_ID_W-1:0]                        cluster_id_i,
  input  logic [cbus_cfg_pkg::CBUS_N_INIT-1:0]                         init_req_i,
  input  logic [cbus_cfg_pkg::CBUS_N_INIT-1:0][cbus_cfg_pkg::CBUS_ADDR_W-1:0] init_addr_i,
  input  logic [cbus_cfg_pkg::CBUS_N_INIT-1:0]                         init_we_i,
  input  logic [cbus_cfg_pkg::CBUS_N_INIT-1:0][cbus_cfg_pkg::CBUS_DATA_W-1:0] init_wdata_i,
  output logic [cbus_cfg_pkg::CBUS_N_INIT-1:0]                         init_rvalid_o,
  output logic [cbus_cfg_pkg::CBUS_N_INIT-1:0][cbus_cfg_pkg::CBUS_DATA_W-1:0] init_rdata_o,
  output logic [cbus_cfg_pkg::CBUS_N_INIT-1:0]                         init_err_o,
  output logic [cbus_cfg_pkg::CBUS_N_TGT-1:0]                          tgt_req_o,
  output logic [cbus_cfg_pkg::CBUS_N_TGT-1:0][cbus_cfg_pkg::CBUS_ADDR_W-1:0]  tgt_addr_o,
  output logic [cbus_cfg_pkg::CBUS_N_TGT-1:0]                          tgt_we_o,
  output logic [cbus_cfg_pkg::CBUS_N_TGT-1:0][cbus_cfg_pkg::CBUS_DATA_W-1:0]  tgt_wdata_o,
  input  logic [cbus_cfg_pkg::CBUS_N_TGT-1:0]                          tgt_rvalid_i,
  input  logic [cbus_cfg_pkg::CBUS_N_TGT-1:0][cbus_cfg_pkg::CBUS_DATA_W-1:0]  tgt_rdata_i
);
  import cbus_cfg_pkg::*;

  logic [CBUS_INIT_IDX_W-1:0] grant;
  logic                       gnt_valid;
  logic                       tgt_en;
  logic                       resp_en;
  logic                       err;
  logic                       timer_start;
  logic                       timeout;

  cbus_link_if link_if ();  // Granted transfer shared by the blocks

  cbus_arbiter_fsm cbus_arbiter_fsm_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .init_req_i    (init_req_i),
    .link          (link_if),
    .timeout_i     (timeout),
    .grant_o       (grant),
    .gnt_valid_o   (gnt_valid),
    .tgt_en_o      (tgt_en),
    .resp_en_o     (resp_en),
    .err_o         (err),
    .timer_start_o (timer_start)
  );

  cbus_timeout_timer cbus_timeout_timer_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .start_i   (timer_start),
    .stop_i    (link_if.rvalid),  // Any target answer stops the count
    .expired_o (timeout)
  );

  cbus_addr_decoder cbus_addr_decoder_inst (
    .cluster_id_i (cluster_id_i),
    .link         (link_if)
  );

  cbus_target_mux cbus_target_mux_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .init_addr_i   (init_addr_i),
    .init_we_i     (init_we_i),
    .init_wdata_i  (init_wdata_i),
    .init_rvalid_o (init_rvalid_o),
    .init_rdata_o  (init_rdata_o),
    .init_err_o    (init_err_o),
    .grant_i       (grant),
    .gnt_valid_i   (gnt_valid),
    .tgt_en_i      (tgt_en),
    .resp_en_i     (resp_en),
    .err_i         (err),
    .tgt_req_o     (tgt_req_o),
    .tgt_addr_o    (tgt_addr_o),
    .tgt_we_o      (tgt_we_o),
    .tgt_wdata_o   (tgt_wdata_o),
    .tgt_rvalid_i  (tgt_rvalid_i),
    .tgt_rdata_i   (tgt_rdata_i),
    .link          (link_if)
  );

endmodule

// File: bench/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  localparam int unsigned HALF_PERIOD  = 5;
  localparam int unsigned RESET_CYCLES = 3;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// File: bench/tb_cluster_bus.sv
module tb_cluster_bus;
  import cbus_cfg_pkg::*;
  import cbus_types_pkg::*;

  localparam int unsigned N_ROUTE  = 24;
  localparam int unsigned N_MISS   = 8;
  localparam int unsigned N_DATA   = 8;
  localparam int unsigned N_FAIR   = 4;  // Reads per initiator in the fairness round
  localparam int unsigned N_XFERS  = N_ROUTE + N_MISS + 2 * N_DATA + 2 + N_FAIR * CBUS_N_INIT;
  localparam int unsigned WATCHDOG = 4 * N_XFERS * (TIMEOUT_CYCLES + 10);
  localparam int unsigned XFER_MAX = TIMEOUT_CYCLES + 10;  // Cycles one transfer may take
  localparam int          NO_TGT   = 3;

  logic                                    clk;
  logic                                    rst_n;
  logic [CLUSTER_ID_W-1:0]                 cluster_id;
  logic [CBUS_N_INIT-1:0]                  init_req;
  logic [CBUS_N_INIT-1:0][CBUS_ADDR_W-1:0] init_addr;
  logic [CBUS_N_INIT-1:0]                  init_we;
  logic [CBUS_N_INIT-1:0][CBUS_DATA_W-1:0] init_wdata;
  logic [CBUS_N_INIT-1:0]                  init_rvalid;
  logic [CBUS_N_INIT-1:0][CBUS_DATA_W-1:0] init_rdata;
  logic [CBUS_N_INIT-1:0]                  init_err;
  logic [CBUS_N_TGT-1:0]                   tgt_req;
  logic [CBUS_N_TGT-1:0][CBUS_ADDR_W-1:0]  tgt_addr;
  logic [CBUS_N_TGT-1:0]                   tgt_we;
  logic [CBUS_N_TGT-1:0][CBUS_DATA_W-1:0]  tgt_wdata;
  wire  [CBUS_N_TGT-1:0]                   tgt_rvalid;
  wire  [CBUS_N_TGT-1:0][CBUS_DATA_W-1:0]  tgt_rdata;
  logic [CBUS_N_TGT-1:0]                   stall;  // Responder never answers
  logic [CBUS_DATA_W-1:0]                  model_mem [CBUS_N_TGT][64];

  // Last sequential transfer as observed on the pins
  logic [CBUS_DATA_W-1:0] res_rdata;
  logic                   res_err;
  logic [CBUS_N_TGT-1:0]  res_seen;
  logic [CBUS_ADDR_W-1:0] res_taddr;
  logic                   res_twe;
  logic [CBUS_DATA_W-1:0] res_twdata;
  int unsigned            res_req_cycles;

  tb_clk_gen tb_clk_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

  cluster_bus_top cluster_bus_top_inst (
    .clk_i (clk), .rst_n_i (rst_n), .cluster_id_i (cluster_id),
    .init_req_i (init_req), .init_addr_i (init_addr), .init_we_i (init_we),
    .init_wdata_i (init_wdata), .init_rvalid_o (init_rvalid), .init_rdata_o (init_rdata),
    .init_err_o (init_err), .tgt_req_o (tgt_req), .tgt_addr_o (tgt_addr), .tgt_we_o (tgt_we),
    .tgt_wdata_o (tgt_wdata), .tgt_rvalid_i (tgt_rvalid), .tgt_rdata_i (tgt_rdata)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic expect_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) abort_run($sformatf("** Error: %s expected 0x%0h actual 0x%0h", name, exp, act));
  endtask

  function automatic logic [CBUS_ADDR_W-1:0] cluster_base();
    return 32'h1000_0000 + (32'(cluster_id) << 22);
  endfunction

  // Address map of the cluster, ext region first since it is open upward
  function automatic int predict_target(input logic [CBUS_ADDR_W-1:0] addr);
    if (addr >= cluster_base() + 32'h40_0000) return int'(TGT_EXT);
    if (addr >= cluster_base() + 32'h20_0000) return int'(TGT_PERIPH);
    if (addr >= cluster_base() && addr < cluster_base() + TCDM_SIZE) return int'(TGT_TCDM);
    return NO_TGT;
  endfunction

  // Kinds 0 to 2 hit TCDM, periph and ext, 3 lies below the base, 4 in the TCDM hole
  function automatic logic [CBUS_ADDR_W-1:0] random_addr(input int kind);
    logic [CBUS_ADDR_W-1:0] base;
    base = cluster_base();
    case (kind)
      0: return base + ($urandom_range(TCDM_SIZE - 1) & ~32'h3);
      1: return base + PERIPH_OFFSET + ($urandom_range(PERIPH_OFFSET - 1) & ~32'h3);
      2: return base + EXT_OFFSET + (($urandom % (~(base + EXT_OFFSET))) & ~32'h3);
      3: return $urandom_range(base - 1) & ~32'h3;
      default: return base + TCDM_SIZE + ($urandom_range(PERIPH_OFFSET - TCDM_SIZE - 1) & ~32'h3);
    endcase
  endfunction

  function automatic logic [CBUS_DATA_W-1:0] fill_word(input int t, input int idx);
    return {8'hA0 + 8'(t), 8'(idx), 8'(~idx), 8'h5A};
  endfunction

  task automatic check_idle_outputs(input string name);
    expect_equal({name, ": tgt_req_o"}, 0, tgt_req);
    expect_equal({name, ": init_rvalid_o"}, 0, init_rvalid);
  endtask

  task automatic run_xfer(input int n, input logic [31:0] addr, input logic we,
                          input logic [31:0] wdata);
    int unsigned cycles;
    cycles         = 0;
    res_seen       = '0;
    res_req_cycles = 0;
    @(posedge clk);
    #1;
    init_req[n]   = 1'b1;
    init_addr[n]  = addr;
    init_we[n]    = we;
    init_wdata[n] = wdata;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > XFER_MAX) abort_run("No response from the bus within the transfer limit");
      for (int t = 0; t < CBUS_N_TGT; t++) begin
        if (tgt_req[t]) begin
          res_taddr  = tgt_addr[t];
          res_twe    = tgt_we[t];
          res_twdata = tgt_wdata[t];
        end
      end
      if (tgt_req != '0) res_req_cycles++;
      res_seen |= tgt_req;
    end while (!init_rvalid[n]);
    expect_equal("response only to the requester", 1 << n, init_rvalid);
    expect_equal("tgt_req_o low at the response", 0, tgt_req);
    res_rdata = init_rdata[n];
    res_err   = init_err[n];
    @(posedge clk);
    #1;
    init_req[n] = 1'b0;
  endtask

  // One transfer against the reference model
  task automatic check_xfer(input string test, input int n, input logic [31:0] addr,
                            input logic we, input logic [31:0] wdata);
    int tgt;
    tgt = predict_target(addr);
    run_xfer(n, addr, we, wdata);
    expect_equal({test, ": init_err_o"}, tgt == NO_TGT, res_err);
    if (tgt == NO_TGT) begin
      expect_equal({test, ": tgt_req_o on a miss"}, 0, res_seen);
    end else begin
      expect_equal({test, ": tgt_req_o routing"}, 1 << tgt, res_seen);
      expect_equal({test, ": tgt_addr_o"}, addr, res_taddr);
      expect_equal({test, ": tgt_we_o"}, we, res_twe);
      if (we) begin
        expect_equal({test, ": tgt_wdata_o"}, wdata, res_twdata);
        model_mem[tgt][addr[7:2]] = wdata;
      end else begin
        expect_equal({test, ": init_rdata_o"}, model_mem[tgt][addr[7:2]], res_rdata);
      end
    end
  endtask

  task automatic check_fairness();
    int unsigned            left [CBUS_N_INIT];
    logic [CBUS_N_INIT-1:0] served;
    logic [CBUS_N_INIT-1:0] got;
    int unsigned            cycles;
    served = '0;
    cycles = 0;
    @(posedge clk);
    #1;
    for (int n = 0; n < CBUS_N_INIT; n++) begin
      left[n]      = N_FAIR;
      init_req[n]  = 1'b1;
      init_we[n]   = 1'b0;
      init_addr[n] = cluster_base() + 4 * N_FAIR * n;  // Own TCDM words per initiator
    end
    while (init_req != '0) begin
      @(negedge clk);
      cycles++;
      if (cycles > N_FAIR * CBUS_N_INIT * XFER_MAX) abort_run("Fairness round did not finish");
      got = init_rvalid;
      for (int n = 0; n < CBUS_N_INIT; n++) begin
        if (got[n]) begin
          if (served[n]) begin  // Second response only after a full round
            expect_equal("fairness: round complete", {CBUS_N_INIT{1'b1}}, served);
            served = '0;
          end
          served[n] = 1'b1;
          expect_equal("fairness: init_rdata_o", model_mem[TGT_TCDM][init_addr[n][7:2]],
                       init_rdata[n]);
          expect_equal("fairness: init_err_o", 0, init_err[n]);
          left[n]--;
        end
      end
      @(posedge clk);
      #1;
      for (int n = 0; n < CBUS_N_INIT; n++) begin
        if (got[n] && left[n] == 0) init_req[n] = 1'b0;
        else if (got[n]) init_addr[n] = init_addr[n] + 4;
      end
    end
  endtask

  // Behavioural targets, 64-word memory indexed by addr[7:2]
  for (genvar t = 0; t < CBUS_N_TGT; t++) begin : g_responder
    logic [CBUS_DATA_W-1:0] mem [64];
    logic                   rvalid;
    logic [CBUS_DATA_W-1:0] rdata;

    assign tgt_rvalid[t] = rvalid;
    assign tgt_rdata[t]  = rdata;

    initial begin
      int unsigned delay;
      logic [5:0]  idx;
      rvalid = 1'b0;
      rdata  = '0;
      for (int i = 0; i < 64; i++) mem[i] = fill_word(t, i);
      forever begin
        @(negedge clk);
        if (tgt_req[t] && !stall[t]) begin
          delay = $urandom_range(6);
          repeat (delay) @(posedge clk);
          @(posedge clk);
          #1;
          idx = tgt_addr[t][7:2];
          if (tgt_we[t]) mem[idx] = tgt_wdata[t];
          rdata  = mem[idx];
          rvalid = 1'b1;
          @(posedge clk);
          #1;
          rvalid = 1'b0;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    abort_run("Watchdog expired before all transfers completed");
  end

  initial begin
    logic [CBUS_ADDR_W-1:0] data_addr [N_DATA];
    int                     writer [N_DATA];
    logic [CBUS_ADDR_W-1:0] region;
    void'($urandom(92));
    cluster_id = CLUSTER_ID_W'($urandom_range(2 ** CLUSTER_ID_W - 1));
    init_req   = '0;
    init_addr  = '0;
    init_we    = '0;
    init_wdata = '0;
    stall      = '0;
    for (int t = 0; t < CBUS_N_TGT; t++) begin
      for (int i = 0; i < 64; i++) model_mem[t][i] = fill_word(t, i);
    end

    while (rst_n !== 1'b1) begin
      @(negedge clk);
      check_idle_outputs("reset");
    end
    @(negedge clk);
    check_idle_outputs("after reset");

    for (int i = 0; i < N_ROUTE; i++) begin
      check_xfer("routing", $urandom_range(3), random_addr(i % 3), $urandom_range(1), $urandom);
    end
    for (int i = 0; i < N_MISS; i++) begin
      check_xfer("unmapped", $urandom_range(3), random_addr(3 + i % 2), $urandom_range(1),
                 $urandom);
    end

    for (int i = 0; i < N_DATA; i++) begin
      region       = (i % 3 == 0) ? '0 : (i % 3 == 1) ? PERIPH_OFFSET : EXT_OFFSET;
      data_addr[i] = cluster_base() + region + 4 * i;
      writer[i]    = $urandom_range(3);
      check_xfer("data write", writer[i], data_addr[i], 1'b1, $urandom);
    end
    for (int i = 0; i < N_DATA; i++) begin
      check_xfer("data read", (writer[i] + 1 + $urandom_range(2)) % 4, data_addr[i], 1'b0, '0);
    end

    stall[TGT_PERIPH] = 1'b1;
    run_xfer(2, random_addr(1), 1'b0, '0);
    expect_equal("timeout: init_err_o", 1, res_err);
    expect_equal("timeout: tgt_req_o routing", 1 << TGT_PERIPH, res_seen);
    expect_equal("timeout: error within the limit", 1,
                 res_req_cycles >= TIMEOUT_CYCLES && res_req_cycles <= TIMEOUT_CYCLES + 4);
    stall = '0;
    check_xfer("after timeout", 2, random_addr(1), 1'b0, '0);

    check_fairness();

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: build.f
design/cbus_cfg_pkg.sv
design/cbus_types_pkg.sv
design/cbus_link_if.sv
design/cbus_arbiter_fsm.sv
design/cbus_timeout_timer.sv
design/cbus_addr_decoder.sv
design/cbus_target_mux.sv
design/cluster_bus_top.sv
bench/tb_clk_gen.sv
bench/tb_cluster_bus.sv

// File: Bender.yml
package:
  name: cluster_bus

sources:
  - files:
      - design/cbus_cfg_pkg.sv
      - design/cbus_types_pkg.sv
      - design/cbus_link_if.sv
      - design/cbus_arbiter_fsm.sv
      - design/cbus_timeout_timer.sv
      - design/cbus_addr_decoder.sv
      - design/cbus_target_mux.sv
      - design/cluster_bus_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_cluster_bus.sv
